/* bus_line.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/stop_if.sv
hdl/button_pulse.sv
hdl/stop_queues.sv
hdl/step_timer.sv
hdl/bus_controller.sv
hdl/bus_line.sv
bench/bus_line_tb.sv

/* Makefile */
# Verilator build for the shuttle bus model

TOP = bus_line_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f bus_line.f --top-module $(TOP)

sim:
	verilator --binary --assert -f bus_line.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* bench/bus_line_stimulus.txt */
# commands: test <name> | press <bottom|top> | wait <led|fuel|revenue> <value> | idle <n>
# expect <fuel> <revenue> <led> | end ; led values are hex, the others decimal
test reset_state
expect 0 0 0001
end
# presses at the top, the bus leaves the bottom after the first one
test top_queue_saturates
press top
expect 0 0 1001
press top
expect 0 0 1801
press top
expect 0 0 1802
end
test trip_bottom_to_top
wait led 1840
expect 0 0 1840
wait led 0640
expect 0 0 0640
wait revenue 40
expect 0 40 0640
wait fuel 10
expect 10 30 0640
wait fuel 20
expect 20 20 0640
end
test loaded_return_leg
wait led 0620
expect 20 20 0620
wait led 0608
expect 10 20 0608
wait fuel 20
expect 20 10 0608
wait led 0601
expect 10 10 0601
wait led 0401
expect 10 10 0401
wait led 0001
expect 10 10 0001
end
test board_at_bottom
press bottom
wait led 0401
expect 10 10 0401
wait revenue 40
expect 10 40 0401
wait fuel 20
expect 20 30 0401
wait led 0402
expect 20 30 0402
wait led 0408
expect 15 30 0408
wait fuel 20
expect 20 20 0408
wait led 0440
expect 15 20 0440
wait led 0040
expect 15 20 0040
wait fuel 20
expect 20 10 0040
# parked in standby, nothing moves
idle 64
expect 20 10 0040
end

/* bench/bus_line_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_line_tb;

    localparam int WAIT_LIMIT = 400; // cycles, well above one leg of the trip

    logic             clk = 1'b0;
    logic             rst;
    logic             btn_bottom;
    logic             btn_top;
    logic [15:0]      led;
    bus_pkg::fuel_t   fuel;
    bus_pkg::money_t  revenue;

    int               fd;
    int               n;
    logic [8*32-1:0]  word;
    logic [8*128-1:0] line;
    string            cmd;
    string            test_name;
    logic             test_ok;
    logic             in_test;
    logic             aborted;
    logic             done;
    int               pass_count;
    int               fail_count;
    int               idle_cycles;
    int               wait_sel;
    logic [15:0]      wait_value;
    bus_pkg::fuel_t   exp_fuel;
    bus_pkg::money_t  exp_revenue;
    logic [15:0]      exp_led;

    bus_line dut_i (
        .clk        (clk),
        .rst        (rst),
        .btn_bottom (btn_bottom),
        .btn_top    (btn_top),
        .led        (led),
        .fuel       (fuel),
        .revenue    (revenue)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // 0 led bar, 1 fuel, 2 revenue
    function automatic logic [15:0] observed(input int sel);
        logic [15:0] value;
        case (sel)
            0:       value = led;
            1:       value = {9'd0, fuel};
            default: value = {9'd0, revenue};
        endcase
        return value;
    endfunction

    task automatic press_button(input logic top);
        if (top) begin
            btn_top = 1'b1;
        end else begin
            btn_bottom = 1'b1;
        end
        repeat (8) @(negedge clk); // held long enough for the debouncer
        btn_top    = 1'b0;
        btn_bottom = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic wait_until(input int sel, input logic [15:0] value);
        int cycles;
        cycles = 0;
        while (observed(sel) != value && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (observed(sel) != value) begin
            case (sel)
                0:       $display("ERROR: %s timed out waiting for led pattern %h",
                                  test_name, value);
                1:       $display("ERROR: %s timed out waiting for fuel %0d",
                                  test_name, value);
                default: $display("ERROR: %s timed out waiting for revenue %0d",
                                  test_name, value);
            endcase
            aborted = 1'b1;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_outputs(input bus_pkg::fuel_t exp_f, input bus_pkg::money_t exp_r,
                                 input logic [15:0] exp_l);
        assert (fuel == exp_f) else begin
            $display("CHECK FAILED: %s fuel expected %0d actual %0d", test_name, exp_f, fuel);
            test_ok = 1'b0;
        end
        assert (revenue == exp_r) else begin
            $display("CHECK FAILED: %s revenue expected %0d actual %0d",
                     test_name, exp_r, revenue);
            test_ok = 1'b0;
        end
        assert (led == exp_l) else begin
            $display("CHECK FAILED: %s led expected %h actual %h", test_name, exp_l, led);
            test_ok = 1'b0;
        end
    endtask

    task automatic close_test();
        if (test_ok) begin
            pass_count = pass_count + 1;
            $display("test %s passed", test_name);
        end else begin
            fail_count = fail_count + 1;
            $display("test %s failed", test_name);
        end
        in_test = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        btn_bottom = 1'b0;
        btn_top    = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_ok    = 1'b1;
        in_test    = 1'b0;
        aborted    = 1'b0;
        test_name  = "none";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("bench/bus_line_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open bench/bus_line_stimulus.txt");
            aborted = 1'b1;
        end
        done = aborted;
        while (!done) begin
            n = $fscanf(fd, "%s", word);
            if (n != 1) begin
                done = 1'b1; // end of file
            end else begin
                cmd = string'(word);
                if (cmd == "#") begin
                    n = $fgets(line, fd);
                end else if (cmd == "test") begin
                    n = $fscanf(fd, "%s", word);
                    test_name = string'(word);
                    test_ok   = 1'b1;
                    in_test   = 1'b1;
                end else if (cmd == "press") begin
                    n = $fscanf(fd, "%s", word);
                    press_button(string'(word) == "top");
                end else if (cmd == "wait") begin
                    n = $fscanf(fd, "%s", word);
                    cmd = string'(word);
                    if (cmd == "led") begin
                        wait_sel = 0;
                        n = $fscanf(fd, "%h", wait_value);
                    end else begin
                        wait_sel = (cmd == "fuel") ? 1 : 2;
                        n = $fscanf(fd, "%d", wait_value);
                    end
                    wait_until(wait_sel, wait_value);
                end else if (cmd == "expect") begin
                    n = $fscanf(fd, "%d %d %h", exp_fuel, exp_revenue, exp_led);
                    check_outputs(exp_fuel, exp_revenue, exp_led);
                end else if (cmd == "idle") begin
                    n = $fscanf(fd, "%d", idle_cycles);
                    repeat (idle_cycles) @(negedge clk);
                end else if (cmd == "end") begin
                    close_test();
                end else begin
                    $display("ERROR: unknown command %s in stimulus file", cmd);
                    aborted = 1'b1;
                    test_ok = 1'b0;
                end
                if (aborted) begin
                    done = 1'b1;
                end
            end
        end
        if (in_test) begin
            close_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !aborted && pass_count > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/bus_line.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_line (
    input  wire             clk,
    input  wire             rst,
    input  wire             btn_bottom,
    input  wire             btn_top,
    output logic [15:0]     led,
    output bus_pkg::fuel_t  fuel,
    output bus_pkg::money_t revenue
);

    logic                  step;
    bus_pkg::track_pos_t   pos;
    bus_pkg::rider_count_t load;

    stop_if stops_i ();

    // 0 -> 00, 1 -> 10, 2 -> 11
    function automatic logic [1:0] therm(input bus_pkg::rider_count_t count);
        return {count != 2'd0, count >= 2'd2};
    endfunction

    stop_queues queues_i (
        .clk        (clk),
        .rst        (rst),
        .btn_bottom (btn_bottom),
        .btn_top    (btn_top),
        .stops      (stops_i.queue)
    );

    step_timer timer_i (
        .clk  (clk),
        .rst  (rst),
        .step (step)
    );

    bus_controller ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .step    (step),
        .stops   (stops_i.bus),
        .pos     (pos),
        .load    (load),
        .fuel    (fuel),
        .revenue (revenue)
    );

    assign led = {therm(stops_i.bottom_waiting), 1'b0,
                  therm(stops_i.top_waiting),
                  therm(load), 2'b00,
                  pos};                           // bus position in [6:0]

endmodule

`default_nettype wire

/* hdl/bus_controller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bus_params.svh"

module bus_controller (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   step,
    stop_if.bus                   stops,
    output bus_pkg::track_pos_t   pos,
    output bus_pkg::rider_count_t load,
    output bus_pkg::fuel_t        fuel,
    output bus_pkg::money_t       revenue
);

    localparam int LAST = `BUS_TRACK_LEN - 1;

    bus_pkg::bus_phase_t   phase;
    logic                  climbing;
    logic                  serve_top;   // terminal being served
    bus_pkg::rider_count_t here_waiting;
    logic                  queues_empty;
    logic                  boarding;
    logic                  can_buy;
    logic [7:0]            fuel_sum;
    bus_pkg::fuel_t        fuel_bought;
    bus_pkg::money_t       fare;
    logic [8:0]            earned;
    logic [8:0]            revenue_sum;
    bus_pkg::money_t       revenue_collected;
    bus_pkg::fuel_t        burn;
    bus_pkg::fuel_t        fuel_burned;
    bus_pkg::track_pos_t   next_pos;
    logic                  lands_terminal;

    assign here_waiting = serve_top ? stops.top_waiting : stops.bottom_waiting;
    assign queues_empty = (stops.bottom_waiting == 2'd0) && (stops.top_waiting == 2'd0);

    // everyone off, so the waiting group boards on this step
    assign boarding = step && (phase == bus_pkg::PHASE_ALIGHT) && (load == 2'd0);
    assign stops.bottom_board = boarding && !serve_top;
    assign stops.top_board    = boarding && serve_top;

    // one fuel purchase
    assign can_buy = (fuel < 7'(`BUS_FUEL_MAX)) && (revenue > 7'(`BUS_FUEL_PRICE));
    assign fuel_sum = {1'b0, fuel} + 8'(`BUS_FUEL_UNIT);
    assign fuel_bought = (fuel_sum > 8'(`BUS_FUEL_MAX)) ? 7'(`BUS_FUEL_MAX) : fuel_sum[6:0];

    // fare income, capped at 127
    assign fare = serve_top ? 7'(`BUS_FARE_TOP) : 7'(`BUS_FARE_BOTTOM);
    assign earned = {7'b0, load} * {2'b0, fare};
    assign revenue_sum = {2'b0, revenue} + earned;
    assign revenue_collected = (revenue_sum > 9'd127) ? 7'd127 : revenue_sum[6:0];

    // fuel burned per leg, never below empty
    assign burn = {5'b0, load} * 7'(`BUS_BURN_PER_RIDER);
    assign fuel_burned = (fuel < burn) ? 7'd0 : fuel - burn;

    assign next_pos = climbing ? {pos[LAST-1:0], 1'b0} : {1'b0, pos[LAST:1]};
    assign lands_terminal = next_pos[0] || next_pos[LAST];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= bus_pkg::PHASE_STANDBY;
            pos       <= {{LAST{1'b0}}, 1'b1}; // parked at the bottom
            climbing  <= 1'b1;
            serve_top <= 1'b0;
            load      <= 2'd0;
            fuel      <= 7'd0;
            revenue   <= 7'd0;
        end else if (step) begin
            case (phase)
                bus_pkg::PHASE_STANDBY: begin
                    if ((pos[0] && stops.bottom_waiting != 2'd0) ||
                        (pos[LAST] && stops.top_waiting != 2'd0)) begin
                        phase     <= bus_pkg::PHASE_ALIGHT;
                        serve_top <= pos[LAST];
                    end else if ((pos[0] && stops.top_waiting != 2'd0) ||
                                 (pos[LAST] && stops.bottom_waiting != 2'd0)) begin
                        // only the far end has people, go fetch them
                        phase    <= bus_pkg::PHASE_RUN;
                        climbing <= pos[0];
                    end
                end
                bus_pkg::PHASE_ALIGHT: begin
                    if (load != 2'd0) begin
                        load <= load - 2'd1; // one rider off per step
                    end else begin
                        load  <= here_waiting;
                        phase <= bus_pkg::PHASE_COLLECT;
                    end
                end
                bus_pkg::PHASE_COLLECT: begin
                    revenue <= revenue_collected;
                    phase   <= bus_pkg::PHASE_REFUEL;
                end
                bus_pkg::PHASE_REFUEL: begin
                    if (can_buy) begin
                        revenue <= revenue - 7'(`BUS_FUEL_PRICE);
                        fuel    <= fuel_bought;
                    end else begin
                        climbing <= !serve_top; // head away from this end
                        if (load == 2'd0 && queues_empty) begin
                            phase <= bus_pkg::PHASE_STANDBY;
                        end else begin
                            phase <= bus_pkg::PHASE_RUN;
                        end
                    end
                end
                bus_pkg::PHASE_RUN: begin
                    if (pos[`BUS_STATION_POS] && can_buy) begin
                        revenue <= revenue - 7'(`BUS_FUEL_PRICE);
                        fuel    <= fuel_bought;
                    end else begin
                        pos <= next_pos;
                        if (next_pos[`BUS_STATION_POS] || lands_terminal) begin
                            fuel <= fuel_burned;
                        end
                        if (lands_terminal) begin
                            phase     <= bus_pkg::PHASE_ALIGHT;
                            serve_top <= next_pos[LAST];
                        end
                    end
                end
                default: phase <= bus_pkg::PHASE_STANDBY;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/step_timer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bus_params.svh"

module step_timer (
    input  wire  clk,
    input  wire  rst,
    output logic step
);

    localparam int CNT_W = $clog2(`BUS_STEP_CYCLES);

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(`BUS_STEP_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            step  <= 1'b0;
        end else begin
            count <= wrap ? '0 : count + 1'b1;
            step  <= wrap; // first tick on the Nth edge after reset
        end
    end

endmodule

`default_nettype wire

/* hdl/stop_queues.sv */
`timescale 1ns/1ns
`default_nettype none

module stop_queues (
    input wire    clk,
    input wire    rst,
    input wire    btn_bottom,
    input wire    btn_top,
    stop_if.queue stops
);

    logic press_bottom;
    logic press_top;

    // saturating waiting count, board clears it
    function automatic bus_pkg::rider_count_t next_count(
        input bus_pkg::rider_count_t count,
        input logic                  press,
        input logic                  board
    );
        bus_pkg::rider_count_t result;
        result = count;
        if (board) begin
            result = press ? 2'd1 : 2'd0; // a press racing the board stays queued
        end else if (press && count != 2'd2) begin
            result = count + 2'd1;
        end
        return result;
    endfunction

    button_pulse bottom_btn_i (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_bottom),
        .press (press_bottom)
    );

    button_pulse top_btn_i (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_top),
        .press (press_top)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stops.bottom_waiting <= 2'd0;
            stops.top_waiting    <= 2'd0;
        end else begin
            stops.bottom_waiting <= next_count(stops.bottom_waiting, press_bottom,
                                               stops.bottom_board);
            stops.top_waiting    <= next_count(stops.top_waiting, press_top,
                                               stops.top_board);
        end
    end

endmodule

`default_nettype wire

/* hdl/button_pulse.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bus_params.svh"

module button_pulse (
    input  wire  clk,
    input  wire  rst,
    input  wire  btn,
    output logic press
);

    logic [`BUS_DEBOUNCE_LEN-1:0] samples;
    logic                         down;
    logic                         down_q;

    // down only once every sample in the window is high
    assign down = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            down_q  <= 1'b0;
            press   <= 1'b0;
        end else begin
            samples <= {samples[`BUS_DEBOUNCE_LEN-2:0], btn};
            down_q  <= down;
            press   <= down & ~down_q; // rising edge of debounced level
        end
    end

endmodule

`default_nettype wire

/* hdl/stop_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface stop_if;

    bus_pkg::rider_count_t bottom_waiting;
    bus_pkg::rider_count_t top_waiting;
    logic                  bottom_board; // one-cycle strobe
    logic                  top_board;

    modport queue (
        output bottom_waiting, top_waiting,
        input  bottom_board, top_board
    );

    modport bus (
        input  bottom_waiting, top_waiting,
        output bottom_board, top_board
    );

endinterface

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

`include "bus_params.svh"

package bus_pkg;

    // passengers waiting or on board, 0 to 2
    typedef logic [1:0] rider_count_t;

    typedef logic [6:0] money_t; // saturates at 127
    typedef logic [6:0] fuel_t;

    typedef enum logic [2:0] {
        PHASE_STANDBY,
        PHASE_ALIGHT,
        PHASE_COLLECT,
        PHASE_REFUEL,
        PHASE_RUN
    } bus_phase_t;

    // one-hot, bit 0 is the bottom stop
    typedef logic [`BUS_TRACK_LEN-1:0] track_pos_t;

endpackage

`default_nettype wire

/* hdl/bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// pacing, short enough for simulation
`define BUS_STEP_CYCLES     16
`define BUS_DEBOUNCE_LEN    4

// track layout
`define BUS_TRACK_LEN       7
`define BUS_STATION_POS     3

// fares per boarding passenger
`define BUS_FARE_BOTTOM     30
`define BUS_FARE_TOP        20

// fuel and its price
`define BUS_FUEL_MAX        20
`define BUS_FUEL_UNIT       10
`define BUS_FUEL_PRICE      10
`define BUS_BURN_PER_RIDER  5

`endif
